// ==== rtl/tcb_bus_pkg.sv ====
/*
 * TCB bus definitions
 * Request and response structs for the simple bus master that
 * reaches the UART register block, plus the bus widths.
 * One access per cycle with trn high, no wait state.
 */

package tcb_bus_pkg;

  //////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////

  localparam int unsigned adr_w = 6;   // Byte address
  localparam int unsigned dat_w = 32;  // Data word

  // Master to slave
  typedef struct packed {
    logic             trn;  // Transfer strobe
    logic             wen;  // Write enable
    logic [adr_w-1:0] adr;  // Byte address
    logic [dat_w-1:0] wdt;  // Write data
  } tcb_req_t;

  // Slave to master, registered read data
  typedef struct packed {
    logic [dat_w-1:0] rdt;
  } tcb_rsp_t;

endpackage

// ==== rtl/uart_pkg.sv ====
/*
 * UART definitions
 * Register map, frame position states, serial data width and
 * the reset values of the configuration registers.
 */

package uart_pkg;

  localparam int unsigned uart_dw = 8;  // 8N1 data bits

  // Register map, byte addresses
  typedef enum logic [5:0] {
    tx_data = 6'h00,  // Write only, push TX FIFO
    tx_load = 6'h04,  // TX FIFO count
    tx_bdr  = 6'h08,  // TX bit time minus 1
    tx_irq  = 6'h10,  // TX level
    rx_data = 6'h20,  // Read pops RX FIFO
    rx_load = 6'h24,  // RX FIFO count
    rx_bdr  = 6'h28,  // RX bit time minus 1
    rx_smp  = 6'h2C,  // RX sample phase
    rx_irq  = 6'h30   // RX level
  } uart_reg_e;

  // Position inside a frame
  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } uart_bit_e;

  // Config reset values
  localparam int unsigned bdr_rst = 7;  // 8 cycles per bit
  localparam int unsigned smp_rst = 3;  // Mid-bit
  localparam int unsigned irq_rst = 0;  // Interrupts quiet

endpackage

// ==== rtl/uart_fifo.sv ====
/*
 * UART FIFO
 * Synchronous circular buffer between a valid/ready input stream
 * and a valid/ready output stream. Reports its occupancy, which
 * changes on the same edge as a transfer.
 */

module uart_fifo #(
  parameter int unsigned sz = 16  // Depth in bytes
) (
  input  logic                       tcb,
  input  logic                       rst_n,
  // Input stream
  input  logic                       sti_vld,
  input  logic [uart_pkg::uart_dw-1:0] sti_dat,
  output logic                       sti_rdy,
  // Output stream
  output logic                       sto_vld,
  output logic [uart_pkg::uart_dw-1:0] sto_dat,
  input  logic                       sto_rdy,
  // Occupancy
  output logic [$clog2(sz+1)-1:0]    cnt
);

  localparam int unsigned aw = $clog2(sz);    // Pointer width
  localparam int unsigned cw = $clog2(sz+1);  // Count width

  logic [uart_pkg::uart_dw-1:0] mem [sz];

  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic          push;  // Byte in
  logic          pop;   // Byte out

  assign sti_rdy = (cnt != cw'(sz));  // Not full
  assign sto_vld = (cnt != '0);       // Not empty
  assign sto_dat = mem[rd_ptr];

  assign push = sti_vld & sti_rdy;
  assign pop  = sto_vld & sto_rdy;

  // Storage
  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= sti_dat;
  end

  //////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == aw'(sz-1)) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == aw'(sz-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push with pop keeps count
      if (push && !pop)      cnt <= cnt + 1'b1;
      else if (pop && !push) cnt <= cnt - 1'b1;
    end
  end

endmodule

// ==== rtl/uart_ser.sv ====
/*
 * UART serializer
 * Takes a byte from the TX FIFO while idle and shifts out an 8N1
 * frame, LSB first. Bit time is cfg_bdr plus 1 cycles, latched
 * at frame start.
 */

module uart_ser #(
  parameter int unsigned rw = 8  // Baud counter width
) (
  input  logic                         tcb,
  input  logic                         rst_n,
  input  logic [rw-1:0]                cfg_bdr,
  // Byte stream from FIFO
  input  logic                         str_vld,
  input  logic [uart_pkg::uart_dw-1:0] str_dat,
  output logic                         str_rdy,
  // Serial line
  output logic                         txd
);

  uart_pkg::uart_bit_e state;

  logic [rw-1:0]                        bdr;    // Latched bit time
  logic [rw-1:0]                        cnt;    // Down counter
  logic [$clog2(uart_pkg::uart_dw)-1:0] bit_n;  // Current data bit
  logic [uart_pkg::uart_dw-1:0]         shr;    // Frame byte
  logic                                 take;

  assign str_rdy = (state == uart_pkg::idle);
  assign take    = str_vld & str_rdy;

  // Byte and bit time held for the whole frame
  always_ff @(posedge tcb) begin
    if (take) begin
      shr <= str_dat;
      bdr <= cfg_bdr;
    end
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::idle;
      cnt   <= '0;
      bit_n <= '0;
      txd   <= 1'b1;  // Line idles high
    end else if (state == uart_pkg::idle) begin
      if (take) begin
        state <= uart_pkg::start;
        cnt   <= cfg_bdr;
        txd   <= 1'b0;  // Start bit next cycle
      end
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end else begin
      cnt <= bdr;  // Bit boundary
      case (state)
        uart_pkg::start: begin
          state <= uart_pkg::data;
          bit_n <= '0;
          txd   <= shr[0];
        end
        uart_pkg::data: begin
          if (bit_n == ($bits(bit_n))'(uart_pkg::uart_dw-1)) begin
            state <= uart_pkg::stop;
            txd   <= 1'b1;  // Stop bit
          end else begin
            bit_n <= bit_n + 1'b1;
            txd   <= shr[bit_n+1'b1];
          end
        end
        default: state <= uart_pkg::idle;  // End of stop
      endcase
    end
  end

endmodule

// ==== rtl/uart_des.sv ====
/*
 * UART deserializer
 * Synchronizes rxd, starts a frame on a falling edge and samples
 * each bit cfg_smp plus 1 cycles into its bit time. A byte with a
 * high stop bit is emitted with a one cycle valid pulse, a framing
 * error drops it.
 */

module uart_des #(
  parameter int unsigned rw = 8  // Baud counter width
) (
  input  logic                         tcb,
  input  logic                         rst_n,
  input  logic [rw-1:0]                cfg_bdr,  // Bit time minus 1
  input  logic [rw-1:0]                cfg_smp,  // Sample phase
  input  logic                         rxd,
  // Byte stream to FIFO, no back-pressure
  output logic                         str_vld,
  output logic [uart_pkg::uart_dw-1:0] str_dat
);

  uart_pkg::uart_bit_e state;

  logic [2:0]                           rxd_sr;  // Two sync flops plus history
  logic                                 rxd_s;   // Synchronized line
  logic                                 fall;    // Start edge
  logic [rw-1:0]                        cnt;     // Phase inside bit
  logic [$clog2(uart_pkg::uart_dw)-1:0] bit_n;
  logic [uart_pkg::uart_dw-1:0]         shr;
  logic                                 smp_hit;
  logic                                 bit_end;

  assign rxd_s   = rxd_sr[1];
  assign fall    = rxd_sr[2] & ~rxd_sr[1];
  assign smp_hit = (cnt == cfg_smp);
  assign bit_end = (cnt == cfg_bdr);
  assign str_dat = shr;  // Stable while valid pulses

  //////////////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) rxd_sr <= '1;  // Idle line
    else        rxd_sr <= {rxd_sr[1:0], rxd};
  end

  // Data bits in LSB first
  always_ff @(posedge tcb) begin
    if (state == uart_pkg::data && smp_hit) shr <= {rxd_s, shr[uart_pkg::uart_dw-1:1]};
  end

  //////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::idle;
      cnt     <= '0;
      bit_n   <= '0;
      str_vld <= 1'b0;
    end else begin
      str_vld <= 1'b0;  // Single cycle pulse
      if (state == uart_pkg::idle) begin
        if (fall) begin
          state <= uart_pkg::start;
          cnt   <= '0;
        end
      end else begin
        cnt <= bit_end ? '0 : cnt + 1'b1;
        case (state)
          uart_pkg::start: begin
            if (smp_hit && rxd_s) begin
              state <= uart_pkg::idle;  // Glitch, not a start bit
            end else if (bit_end) begin
              state <= uart_pkg::data;
              bit_n <= '0;
            end
          end
          uart_pkg::data: begin
            if (bit_end) begin
              if (bit_n == ($bits(bit_n))'(uart_pkg::uart_dw-1)) state <= uart_pkg::stop;
              else                                               bit_n <= bit_n + 1'b1;
            end
          end
          default: begin
            // Framing check, leave early to catch the next start edge
            if (smp_hit) begin
              state   <= uart_pkg::idle;
              str_vld <= rxd_s;
            end else if (bit_end) begin
              state <= uart_pkg::idle;  // Sample phase past bit end
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/uart_regs.sv ====
/*
 * UART register block
 * Decodes bus accesses, holds baud, sample and interrupt level
 * registers, pushes TX data, pops RX data and compares FIFO
 * loads with the levels. Read data is registered, one cycle late.
 */

module uart_regs #(
  parameter int unsigned rw = 8,   // Baud counter width
  parameter int unsigned sz = 16   // FIFO depth
) (
  input  logic                         tcb,
  input  logic                         rst_n,
  // Bus
  input  tcb_bus_pkg::tcb_req_t        req,
  output tcb_bus_pkg::tcb_rsp_t        rsp,
  // TX FIFO push
  output logic                         tx_vld,
  output logic [uart_pkg::uart_dw-1:0] tx_dat,
  input  logic                         tx_rdy,
  // RX FIFO pop
  input  logic [uart_pkg::uart_dw-1:0] rx_dat,
  output logic                         rx_rdy,
  // FIFO loads
  input  logic [$clog2(sz+1)-1:0]      tx_cnt,
  input  logic [$clog2(sz+1)-1:0]      rx_cnt,
  // Configuration
  output logic [rw-1:0]                tx_bdr,
  output logic [rw-1:0]                rx_bdr,
  output logic [rw-1:0]                rx_smp,
  // Interrupts
  output logic                         irq_tx,
  output logic                         irq_rx
);

  localparam int unsigned cw = $clog2(sz+1);  // Count width

  uart_pkg::uart_reg_e adr;

  logic [cw-1:0]                   tx_lvl;  // TX level
  logic [cw-1:0]                   rx_lvl;  // RX level
  logic                            wr;
  logic                            rd;
  logic [tcb_bus_pkg::dat_w-1:0]   rd_mux;

  assign adr = uart_pkg::uart_reg_e'(req.adr);
  assign wr  = req.trn &  req.wen;
  assign rd  = req.trn & ~req.wen;

  // Full FIFO drops the write
  assign tx_vld = wr & (adr == uart_pkg::tx_data) & tx_rdy;
  assign tx_dat = req.wdt[uart_pkg::uart_dw-1:0];
  assign rx_rdy = rd & (adr == uart_pkg::rx_data);

  //////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;  // Unmapped and write only
    case (adr)
      uart_pkg::tx_load: rd_mux[cw-1:0] = tx_cnt;
      uart_pkg::tx_bdr:  rd_mux[rw-1:0] = tx_bdr;
      uart_pkg::tx_irq:  rd_mux[cw-1:0] = tx_lvl;
      uart_pkg::rx_data: if (rx_cnt != '0) rd_mux[uart_pkg::uart_dw-1:0] = rx_dat;  // Empty reads 0
      uart_pkg::rx_load: rd_mux[cw-1:0] = rx_cnt;
      uart_pkg::rx_bdr:  rd_mux[rw-1:0] = rx_bdr;
      uart_pkg::rx_smp:  rd_mux[rw-1:0] = rx_smp;
      uart_pkg::rx_irq:  rd_mux[cw-1:0] = rx_lvl;
      default: ;
    endcase
  end

  // Held until the next read
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n)  rsp.rdt <= '0;
    else if (rd) rsp.rdt <= rd_mux;
  end

  //////////////////////////////////////////////////////////
  // Configuration writes
  //////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      tx_bdr <= rw'(uart_pkg::bdr_rst);
      tx_lvl <= cw'(uart_pkg::irq_rst);
      rx_bdr <= rw'(uart_pkg::bdr_rst);
      rx_smp <= rw'(uart_pkg::smp_rst);
      rx_lvl <= cw'(uart_pkg::irq_rst);
    end else if (wr) begin
      case (adr)
        uart_pkg::tx_bdr: tx_bdr <= req.wdt[rw-1:0];  // Masked to width
        uart_pkg::tx_irq: tx_lvl <= req.wdt[cw-1:0];
        uart_pkg::rx_bdr: rx_bdr <= req.wdt[rw-1:0];
        uart_pkg::rx_smp: rx_smp <= req.wdt[rw-1:0];
        uart_pkg::rx_irq: rx_lvl <= req.wdt[cw-1:0];
        default: ;  // Data and load ignore writes
      endcase
    end
  end

  // Level interrupts, one cycle behind the counts
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      irq_tx <= 1'b0;
      irq_rx <= 1'b0;
    end else begin
      irq_tx <= (tx_cnt < tx_lvl);  // Room to refill
      irq_rx <= (rx_cnt > rx_lvl);  // Bytes waiting
    end
  end

endmodule

// ==== rtl/uart_ctrl.sv ====
/*
 * UART controller top level
 * Register block on the TCB bus, TX FIFO into the serializer and
 * deserializer into the RX FIFO, with two level interrupts.
 */

module uart_ctrl #(
  parameter int unsigned rw = 8,   // Baud counter width
  parameter int unsigned sz = 16   // FIFO depth
) (
  input  logic                  tcb,
  input  logic                  rst_n,
  input  tcb_bus_pkg::tcb_req_t req,
  output tcb_bus_pkg::tcb_rsp_t rsp,
  input  logic                  uart_rxd,
  output logic                  uart_txd,
  output logic                  irq_tx,  // TX load below level
  output logic                  irq_rx   // RX load above level
);

  localparam int unsigned cw = $clog2(sz+1);

  // Bus side streams
  logic                         tx_bus_vld, tx_bus_rdy;
  logic [uart_pkg::uart_dw-1:0] tx_bus_dat, rx_bus_dat;
  logic                         rx_bus_vld, rx_bus_rdy;
  // Serial side streams
  logic                         tx_str_vld, tx_str_rdy;
  logic [uart_pkg::uart_dw-1:0] tx_str_dat, rx_str_dat;
  logic                         rx_str_vld, rx_str_rdy;
  // Status and config
  logic [cw-1:0]                tx_cnt, rx_cnt;
  logic [rw-1:0]                tx_bdr, rx_bdr, rx_smp;

  uart_regs #(.rw(rw), .sz(sz)) regs (
    .tcb, .rst_n, .req, .rsp,
    .tx_vld (tx_bus_vld), .tx_dat (tx_bus_dat), .tx_rdy (tx_bus_rdy),
    .rx_dat (rx_bus_dat), .rx_rdy (rx_bus_rdy),
    .tx_cnt, .rx_cnt, .tx_bdr, .rx_bdr, .rx_smp,
    .irq_tx, .irq_rx
  );

  //////////////////////////////////////////////////////////
  // TX path
  //////////////////////////////////////////////////////////

  uart_fifo #(.sz(sz)) tx_fifo (
    .tcb, .rst_n,
    .sti_vld (tx_bus_vld), .sti_dat (tx_bus_dat), .sti_rdy (tx_bus_rdy),
    .sto_vld (tx_str_vld), .sto_dat (tx_str_dat), .sto_rdy (tx_str_rdy),
    .cnt     (tx_cnt)
  );

  uart_ser #(.rw(rw)) ser (
    .tcb, .rst_n, .cfg_bdr (tx_bdr),
    .str_vld (tx_str_vld), .str_dat (tx_str_dat), .str_rdy (tx_str_rdy),
    .txd     (uart_txd)
  );

  //////////////////////////////////////////////////////////
  // RX path
  //////////////////////////////////////////////////////////

  // rx_str_rdy low means the byte is lost
  uart_fifo #(.sz(sz)) rx_fifo (
    .tcb, .rst_n,
    .sti_vld (rx_str_vld), .sti_dat (rx_str_dat), .sti_rdy (rx_str_rdy),
    .sto_vld (rx_bus_vld), .sto_dat (rx_bus_dat), .sto_rdy (rx_bus_rdy),
    .cnt     (rx_cnt)
  );

  uart_des #(.rw(rw)) des (
    .tcb, .rst_n, .cfg_bdr (rx_bdr), .cfg_smp (rx_smp),
    .rxd     (uart_rxd),
    .str_vld (rx_str_vld), .str_dat (rx_str_dat)
  );

endmodule

// ==== test/uart_ctrl_properties.sv ====
/*
 * UART controller assertions
 * FIFO count bounds, read data held between reads and the
 * idle level of the serial output around reset.
 */

module uart_ctrl_properties #(
  parameter int unsigned sz = 16  // FIFO depth
) (
  input logic                    tcb,
  input logic                    rst_n,
  input tcb_bus_pkg::tcb_req_t   req,
  input tcb_bus_pkg::tcb_rsp_t   rsp,
  input logic [$clog2(sz+1)-1:0] tx_cnt,
  input logic [$clog2(sz+1)-1:0] rx_cnt,
  input logic                    uart_txd
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  tx_cnt_bound: assert property (@(posedge tcb) disable iff (!rst_n) tx_cnt <= sz)
    else begin
      $error("TX FIFO count above depth");
      fail_cnt++;
    end

  rx_cnt_bound: assert property (@(posedge tcb) disable iff (!rst_n) rx_cnt <= sz)
    else begin
      $error("RX FIFO count above depth");
      fail_cnt++;
    end

  // rdt moves only on the edge of a read strobe
  rdt_hold: assert property (@(posedge tcb) disable iff (!rst_n)
    !$stable(rsp.rdt) |-> $past(req.trn && !req.wen))
    else begin
      $error("read data changed without a read");
      fail_cnt++;
    end

  // Idle high in reset and right after
  txd_idle: assert property (@(posedge tcb) !rst_n |=> uart_txd)
    else begin
      $error("serial output low around reset");
      fail_cnt++;
    end

endmodule

bind uart_ctrl uart_ctrl_properties #(.sz(sz)) props (
  .tcb, .rst_n, .req, .rsp, .tx_cnt, .rx_cnt, .uart_txd
);

// ==== test/uart_ctrl_tb.sv ====
/*
 * UART controller testbench
 * Directed tests for register access, transmit, receive, loopback,
 * interrupts and TX overflow. Serial frames are driven and checked
 * bit by bit. Bus accesses go through the TCB strobe.
 */

module uart_ctrl_tb;

  localparam int unsigned rw = 8;
  localparam int unsigned sz = 16;
  localparam int unsigned cw = $clog2(sz+1);  // FIFO count width

  typedef logic [tcb_bus_pkg::adr_w-1:0] adr_t;

  logic                  tcb;
  logic                  rst_n;
  tcb_bus_pkg::tcb_req_t req;
  tcb_bus_pkg::tcb_rsp_t rsp;
  wire                   uart_rxd;
  logic                  uart_txd;
  logic                  irq_tx;
  logic                  irq_rx;

  logic   rxd_drv;    // Line driven by send_frame
  logic   loopback;   // TX fed back into RX
  integer seed;
  string  test_name;

  assign uart_rxd = loopback ? uart_txd : rxd_drv;

  uart_ctrl #(.rw(rw), .sz(sz)) dut (
    .tcb, .rst_n, .req, .rsp, .uart_rxd, .uart_txd, .irq_tx, .irq_rx
  );

  always #20 tcb = ~tcb;  // 40 unit period

  //////////////////////////////////////////////////////////////
  // Checks and bus access
  //////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  // Any failed bound assertion ends the run
  always @(dut.props.fail_cnt) begin
    if (dut.props.fail_cnt != 0) abort_run("a bound assertion on the DUT failed");
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      abort_run($sformatf("ERR %s %s expected %0h actual %0h", test_name, what, exp, act));
  endtask

  // Edge plus 1 where all inputs change
  task automatic step(input int n);
    repeat (n) begin
      @(posedge tcb);
      #1;
    end
  endtask

  task automatic bus_write(input adr_t adr, input logic [31:0] wdt);
    req.trn = 1'b1;
    req.wen = 1'b1;
    req.adr = adr;
    req.wdt = wdt;
    step(1);        // Write lands on this edge
    req.trn = 1'b0;
    req.wen = 1'b0;
  endtask

  task automatic bus_read(input adr_t adr, output logic [31:0] rdt);
    req.trn = 1'b1;
    req.wen = 1'b0;
    req.adr = adr;
    step(1);
    req.trn = 1'b0;
    rdt     = rsp.rdt;  // Registered so valid after the edge
  endtask

  task automatic expect_reg(input string what, input adr_t adr, input logic [31:0] exp);
    logic [31:0] val;
    bus_read(adr, val);
    check(what, exp, val);
  endtask

  // Read back masked to the field width
  task automatic write_check(input string what, input adr_t adr, input logic [31:0] wdt,
                             input int w);
    bus_write(adr, wdt);
    expect_reg(what, adr, wdt & ((32'h1 << w) - 1));
  endtask

  task automatic poll_reg(input adr_t adr, input logic [31:0] exp, input int limit);
    logic [31:0] val;
    int          n;
    n = 0;
    bus_read(adr, val);
    while (val !== exp) begin
      if (n == limit) abort_run($sformatf("register %0h never reached %0d", adr, exp));
      n++;
      bus_read(adr, val);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Serial driver and monitor
  //////////////////////////////////////////////////////////////

  task automatic send_frame(input logic [7:0] b, input int bt, input logic stop_bit);
    int i;
    rxd_drv = 1'b0;  // Start
    step(bt);
    for (i = 0; i < 8; i++) begin
      rxd_drv = b[i];  // LSB first
      step(bt);
    end
    rxd_drv = stop_bit;
    step(bt);
    rxd_drv = 1'b1;    // Idle gap of one bit
    step(bt);
  endtask

  task automatic wait_txd_low(input int limit);
    int n;
    n = 0;
    while (uart_txd !== 1'b0) begin
      if (n == limit) abort_run("no start bit on uart_txd before the timeout");
      n++;
      step(1);
    end
  endtask

  task automatic recv_frame(input int bt, output logic [7:0] b);
    int i;
    wait_txd_low(bt * 20);
    step(bt / 2);  // Middle of start bit
    if (uart_txd !== 1'b0) abort_run("start bit on uart_txd shorter than half a bit");
    for (i = 0; i < 8; i++) begin
      step(bt);
      b[i] = uart_txd;
    end
    step(bt);
    if (uart_txd !== 1'b1) abort_run("stop bit on uart_txd is low");
  endtask

  //////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////

  task automatic reg_access();
    test_name = "reset_regs";
    check("uart_txd", 1, uart_txd);
    check("irq_tx", 0, irq_tx);
    check("irq_rx", 0, irq_rx);
    check("rdt", 0, rsp.rdt);
    expect_reg("tx_bdr", uart_pkg::tx_bdr, uart_pkg::bdr_rst);
    expect_reg("tx_irq", uart_pkg::tx_irq, uart_pkg::irq_rst);
    expect_reg("rx_bdr", uart_pkg::rx_bdr, uart_pkg::bdr_rst);
    expect_reg("rx_irq", uart_pkg::rx_irq, uart_pkg::irq_rst);
    expect_reg("tx_load", uart_pkg::tx_load, 0);
    expect_reg("rx_load", uart_pkg::rx_load, 0);
    expect_reg("tx_data", uart_pkg::tx_data, 0);   // Write only
    expect_reg("unmapped", 6'h3c, 0);
    expect_reg("rx_smp", uart_pkg::rx_smp, uart_pkg::smp_rst);
    bus_write(uart_pkg::tx_load, 5);                // Ignored
    check("rdt held", uart_pkg::smp_rst, rsp.rdt);
    expect_reg("tx_load write", uart_pkg::tx_load, 0);
    write_check("tx_bdr mask", uart_pkg::tx_bdr, 32'hffff_ff5a, rw);
    write_check("tx_irq mask", uart_pkg::tx_irq, 32'hffff_fff3, cw);
    write_check("rx_bdr mask", uart_pkg::rx_bdr, 32'h0000_1234, rw);
    write_check("rx_smp mask", uart_pkg::rx_smp, 32'h8000_00a5, rw);
    write_check("rx_irq mask", uart_pkg::rx_irq, 32'h0000_003e, cw);
    bus_write(uart_pkg::tx_irq, 0);
    bus_write(uart_pkg::rx_irq, 0);
  endtask

  task automatic transmit_byte();
    logic [7:0] b;
    logic [7:0] got;
    int         n;
    test_name = "transmit";
    bus_write(uart_pkg::tx_bdr, 7);
    bus_write(uart_pkg::tx_data, 8'hff);  // Only the start bit is low
    wait_txd_low(200);
    n = 0;
    while (uart_txd === 1'b0) begin
      if (n == 100) abort_run("start bit on uart_txd never ended");
      n++;
      step(1);
    end
    check("start bit cycles", 8, n);
    b = 8'($random(seed));
    bus_write(uart_pkg::tx_data, b);
    recv_frame(8, got);
    check("tx byte", b, got);
  endtask

  task automatic receive_bytes();
    logic [7:0] b [3];
    logic [7:0] good;
    int         i;
    test_name = "receive";
    bus_write(uart_pkg::rx_bdr, 7);
    bus_write(uart_pkg::rx_smp, 3);
    for (i = 0; i < 3; i++) begin
      b[i] = 8'($random(seed));
      send_frame(b[i], 8, 1'b1);
    end
    poll_reg(uart_pkg::rx_load, 3, 100);
    for (i = 0; i < 3; i++) expect_reg("rx byte", uart_pkg::rx_data, b[i]);
    expect_reg("rx_load drained", uart_pkg::rx_load, 0);
    good = 8'($random(seed));
    send_frame(8'($random(seed)), 8, 1'b0);  // Framing error
    send_frame(good, 8, 1'b1);
    expect_reg("rx_load after bad stop", uart_pkg::rx_load, 1);
    expect_reg("byte after bad stop", uart_pkg::rx_data, good);
  endtask

  task automatic loopback_bytes();
    logic [7:0] q [$];
    int         i;
    test_name = "loopback";
    loopback  = 1'b1;
    for (i = 0; i < 10; i++) begin
      q.push_back(8'($random(seed)));
      bus_write(uart_pkg::tx_data, q[i]);
    end
    poll_reg(uart_pkg::rx_load, 10, 2000);
    for (i = 0; i < 10; i++) expect_reg("looped byte", uart_pkg::rx_data, q[i]);
    expect_reg("tx_load drained", uart_pkg::tx_load, 0);
  endtask

  task automatic irq_levels();
    logic [7:0] q [$];
    int         i;
    test_name = "interrupts";
    bus_write(uart_pkg::tx_irq, 2);
    bus_write(uart_pkg::rx_irq, 1);
    step(3);
    check("irq_tx empty", 1, irq_tx);
    check("irq_rx empty", 0, irq_rx);
    for (i = 0; i < 4; i++) begin
      q.push_back(8'($random(seed)));
      bus_write(uart_pkg::tx_data, q[i]);
    end
    step(3);
    check("irq_tx loaded", 0, irq_tx);  // One in serializer and three queued
    poll_reg(uart_pkg::rx_load, 1, 500);
    step(3);
    check("irq_rx at 1", 0, irq_rx);
    poll_reg(uart_pkg::rx_load, 2, 500);
    step(3);
    check("irq_rx at 2", 1, irq_rx);
    poll_reg(uart_pkg::rx_load, 4, 500);
    step(3);
    check("irq_tx drained", 1, irq_tx);
    for (i = 0; i < 3; i++) expect_reg("rx byte", uart_pkg::rx_data, q[i]);
    step(3);
    check("irq_rx back at 1", 0, irq_rx);
    expect_reg("last rx byte", uart_pkg::rx_data, q[3]);
  endtask

  task automatic tx_overflow();
    logic [7:0]  q [$];
    logic [7:0]  b;
    logic [31:0] load;
    int          i;
    int          j;
    test_name = "overflow";
    loopback  = 1'b0;
    bus_write(uart_pkg::tx_bdr, 63);  // 64 cycle bit
    for (i = 0; i < 20; i++) q.push_back(8'($random(seed)));
    fork
      begin
        for (i = 0; i < 20; i++) bus_write(uart_pkg::tx_data, q[i]);
        bus_read(uart_pkg::tx_load, load);
        check("tx_load bound", 1, load <= sz);
        check("tx_load full", sz, load);
      end
      // Depth plus the byte already in the serializer
      for (j = 0; j < sz + 1; j++) begin
        recv_frame(64, b);
        check("frame byte", q[j], b);
      end
    join
    for (i = 0; i < 20 * 64; i++) begin
      if (uart_txd !== 1'b1) abort_run("frame on uart_txd beyond the accepted bytes");
      step(1);
    end
    expect_reg("tx_load empty", uart_pkg::tx_load, 0);
  endtask

  initial begin
    seed      = 32'h037b_e179;
    tcb       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    rxd_drv   = 1'b1;  // Idle line
    loopback  = 1'b0;
    test_name = "reset";
    repeat (5) @(posedge tcb);
    #1;
    rst_n = 1'b1;
    reg_access();
    transmit_byte();
    receive_bytes();
    loopback_bytes();
    irq_levels();
    tx_overflow();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== uart_ctrl.f ====
rtl/tcb_bus_pkg.sv
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_ser.sv
rtl/uart_des.sv
rtl/uart_regs.sv
rtl/uart_ctrl.sv
test/uart_ctrl_properties.sv
test/uart_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: uart_ctrl

sources:
  # Packages first, then leaf modules up to the top level
  - files:
      - rtl/tcb_bus_pkg.sv
      - rtl/uart_pkg.sv
      - rtl/uart_fifo.sv
      - rtl/uart_ser.sv
      - rtl/uart_des.sv
      - rtl/uart_regs.sv
      - rtl/uart_ctrl.sv
  # Testbench with bound assertions
  - target: test
    files:
      - test/uart_ctrl_properties.sv
      - test/uart_ctrl_tb.sv
